// ==== list.f ====
verilog/bvhPkg.sv
verilog/nodeStack.sv
verilog/childDecode.sv
verilog/traversalFsm.sv
verilog/bvhTraversal.sv
sim/bvhTraversal_properties.sv
sim/bvhTraversalTb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module bvhTraversalTb -f list.f -o simv
	./obj_dir/simv +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then exit 1; fi
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/bvhTraversalTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bvhTraversalTb
    import bvhPkg::*;
();

    localparam int NUM_TREES = 20;
    localparam int MAX_NODES = 15;
    localparam int WATCHDOG_NS = NUM_TREES * (2 * 16 + 10) * 10 + 1000;

    logic                        clk = 1'b0;
    logic                        resetn;
    logic                        start;
    logic                        restart;
    logic                        nodeHit;
    logic [NODE_INDEX_WIDTH-1:0] childIndex [2];
    logic                        leafHit [2];
    logic [PRIM_INDEX_WIDTH-1:0] leafStart [2];
    logic [PRIM_COUNT_WIDTH-1:0] leafCount [2];
    logic [NODE_INDEX_WIDTH-1:0] nodeIndex;
    logic                        valid;
    logic [PRIM_INDEX_WIDTH-1:0] startPrim [2];
    logic [PRIM_COUNT_WIDTH-1:0] numPrim [2];
    logic                        finished;

    // Node memory contents of the current tree
    logic                        memHit [16];
    logic [NODE_INDEX_WIDTH-1:0] memChild [16][2];
    logic                        memLeafHit [16][2];
    logic [PRIM_INDEX_WIDTH-1:0] memStart [16][2];
    logic [PRIM_COUNT_WIDTH-1:0] memCount [16][2];

    // Expected visit order and leaf slots with two entries per report
    int                          expVisit [$];
    logic [PRIM_INDEX_WIDTH-1:0] expStart [$];
    logic [PRIM_COUNT_WIDTH-1:0] expCount [$];
    int                          compareErrors = 0;

    always #5 clk = ~clk;

    bvhTraversal #(
        .STACK_DEPTH(16)
    ) u_dut (
        .clk       (clk),
        .resetn    (resetn),
        .start     (start),
        .restart   (restart),
        .nodeHit   (nodeHit),
        .childIndex(childIndex),
        .leafHit   (leafHit),
        .leafStart (leafStart),
        .leafCount (leafCount),
        .nodeIndex (nodeIndex),
        .valid     (valid),
        .startPrim (startPrim),
        .numPrim   (numPrim),
        .finished  (finished)
    );

    // Combinational node memory
    always_comb begin
        nodeHit = (nodeIndex < 8'd16) ? memHit[nodeIndex[3:0]] : 1'b0;
        for (int i = 0; i < 2; i++) begin
            childIndex[i] = memChild[nodeIndex[3:0]][i];
            leafHit[i] = memLeafHit[nodeIndex[3:0]][i];
            leafStart[i] = memStart[nodeIndex[3:0]][i];
            leafCount[i] = memCount[nodeIndex[3:0]][i];
        end
    end

    // ------------------------------------------------------------------------
    // Tree model and software walk
    // ------------------------------------------------------------------------

    task automatic buildTree();
        int nodeCount;
        for (int n = 0; n < 16; n++) begin
            memHit[n] = 1'b0;
            for (int i = 0; i < 2; i++) begin
                memChild[n][i] = {1'b1, 7'(2 * n + i)};
                memLeafHit[n][i] = 1'b0;
                memStart[n][i] = NULL_PRIM_INDEX;
                memCount[n][i] = '0;
            end
        end
        nodeCount = 1;
        // New inner nodes take the next free index in breadth first order
        for (int n = 0; n < MAX_NODES; n++) begin
            if (n < nodeCount) begin
                memHit[n] = ($urandom % 4) != 0;
                for (int i = 0; i < 2; i++) begin
                    if (nodeCount < MAX_NODES && ($urandom % 2) == 0) begin
                        memChild[n][i] = NODE_INDEX_WIDTH'(nodeCount);
                        nodeCount++;
                    end else begin
                        memLeafHit[n][i] = ($urandom % 4) != 0;
                        memStart[n][i] = PRIM_INDEX_WIDTH'($urandom % 32'hffff);
                        memCount[n][i] = PRIM_COUNT_WIDTH'(1 + $urandom % 15);
                    end
                end
            end
        end
    endtask

    task automatic walkTree();
        int   pending [$];
        int   n;
        logic seen [2];
        expVisit.delete();
        expStart.delete();
        expCount.delete();
        pending.push_back(0);
        while (pending.size() > 0) begin
            n = pending.pop_back();
            expVisit.push_back(n);
            for (int i = 0; i < 2; i++) begin
                seen[i] = memHit[n] && memChild[n][i][LEAF_FLAG_BIT] && memLeafHit[n][i];
                if (memHit[n] && !memChild[n][i][LEAF_FLAG_BIT]) begin
                    pending.push_back(int'(memChild[n][i]));
                end
            end
            if (seen[0] || seen[1]) begin
                for (int i = 0; i < 2; i++) begin
                    expStart.push_back(seen[i] ? memStart[n][i] : NULL_PRIM_INDEX);
                    expCount.push_back(seen[i] ? memCount[n][i] : '0);
                end
            end
        end
    endtask

    task automatic checkValue(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("Error at %0t: %s = %0h, expected %0h", $time, name, got, expected);
            compareErrors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // One traversal with an optional restart at cycle abortAt
    // ------------------------------------------------------------------------

    task automatic runTree(input int abortAt);
        int   cycles;
        int   reports;
        logic aborted;
        cycles = 0;
        reports = 0;
        aborted = 1'b0;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        while (!finished && !aborted) begin
            // Even cycles are Process cycles of the next visited node
            if (cycles % 2 == 0) begin
                if (cycles / 2 < expVisit.size()) begin
                    checkValue("nodeIndex", int'(nodeIndex), expVisit[cycles / 2]);
                end else begin
                    $display("Unit visited more nodes than the tree walk expects");
                    compareErrors++;
                end
            end
            if (valid) begin
                if (2 * reports < expStart.size()) begin
                    for (int i = 0; i < 2; i++) begin
                        checkValue($sformatf("startPrim[%0d]", i), int'(startPrim[i]),
                            int'(expStart[2 * reports + i]));
                        checkValue($sformatf("numPrim[%0d]", i), int'(numPrim[i]),
                            int'(expCount[2 * reports + i]));
                    end
                end else begin
                    $display("Unit reported a leaf after all expected leaves");
                    compareErrors++;
                end
                reports++;
            end
            if (cycles == abortAt) begin
                aborted = 1'b1;
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
        if (!aborted) begin
            checkValue("finish cycle", cycles, 2 * expVisit.size());
            checkValue("leaf reports", reports, expStart.size() / 2);
            repeat (3) begin
                @(negedge clk);
                checkValue("finished", int'(finished), 1);
            end
        end
        @(posedge clk);
        restart <= 1'b1;
        @(posedge clk);
        restart <= 1'b0;
        @(negedge clk);
        checkValue("finished", int'(finished), 1);
        checkValue("valid", int'(valid), 0);
    endtask

    initial begin
        int abortAt;
        int assertErrors;
        void'($urandom(32'h0210693d));
        resetn = 1'b0;
        start = 1'b0;
        restart = 1'b0;
        buildTree();
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        for (int t = 0; t < NUM_TREES; t++) begin
            buildTree();
            walkTree();
            // A few trees get cut short by a restart
            abortAt = (t % 6 == 4) ? int'($urandom % (2 * expVisit.size())) : -1;
            runTree(abortAt);
        end
        repeat (2) @(posedge clk);
        assertErrors = u_dut.u_props.failCount;
        $display("Run complete with %0d compare errors and %0d assertion failures",
            compareErrors, assertErrors);
        if (compareErrors == 0 && assertErrors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all trees were traversed");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/bvhTraversal_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module bvhTraversalProperties
    import bvhPkg::*;
(
    input logic                        clk,
    input logic                        resetn,
    input logic                        start,
    input logic                        restart,
    input logic                        valid,
    input logic                        finished,
    input logic [PRIM_INDEX_WIDTH-1:0] startPrim [2],
    input logic [PRIM_COUNT_WIDTH-1:0] numPrim [2]
);

    int failCount = 0;

    // ------------------------------------------------------------------------
    // Idle behavior after reset and restart
    // ------------------------------------------------------------------------

    resetIdle: assert property (@(posedge clk) $rose(resetn) |-> (finished && !valid))
        else begin
            failCount++;
            $error("finished or valid wrong right after reset");
        end

    restartIdle: assert property (@(posedge clk) disable iff (!resetn)
        restart |=> (finished && !valid))
        else begin
            failCount++;
            $error("restart did not return the unit to idle");
        end

    // Finished holds until a new start
    finishedHolds: assert property (@(posedge clk) disable iff (!resetn)
        (finished && !start) |=> finished)
        else begin
            failCount++;
            $error("finished dropped without a start");
        end

    finishedQuiet: assert property (@(posedge clk) disable iff (!resetn)
        finished |-> !valid)
        else begin
            failCount++;
            $error("valid raised while finished");
        end

    validHasLeaf: assert property (@(posedge clk) disable iff (!resetn)
        valid |-> (numPrim[0] != '0 || numPrim[1] != '0))
        else begin
            failCount++;
            $error("valid raised with both slots empty");
        end

    // ------------------------------------------------------------------------
    // Per slot checks
    // ------------------------------------------------------------------------

    for (genvar i = 0; i < 2; i++) begin : slotChecks
        emptyWhenInvalid: assert property (@(posedge clk) disable iff (!resetn)
            !valid |-> (startPrim[i] == NULL_PRIM_INDEX && numPrim[i] == '0))
            else begin
                failCount++;
                $error("slot %0d not empty while valid is low", i);
            end

        // Count 0 and the null start always go together
        slotConsistent: assert property (@(posedge clk) disable iff (!resetn)
            (numPrim[i] == '0) == (startPrim[i] == NULL_PRIM_INDEX))
            else begin
                failCount++;
                $error("slot %0d start and count disagree", i);
            end
    end

endmodule

bind bvhTraversal bvhTraversalProperties u_props (
    .clk      (clk),
    .resetn   (resetn),
    .start    (start),
    .restart  (restart),
    .valid    (valid),
    .finished (finished),
    .startPrim(startPrim),
    .numPrim  (numPrim)
);

`default_nettype wire

// ==== verilog/bvhTraversal.sv ====
`timescale 1ns/1ps
`default_nettype none

module bvhTraversal
    import bvhPkg::*;
#(
    parameter int STACK_DEPTH = 16
) (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        start,
    input  logic                        restart,
    // Node memory return
    input  logic                        nodeHit,
    input  logic [NODE_INDEX_WIDTH-1:0] childIndex [2],
    input  logic                        leafHit [2],
    input  logic [PRIM_INDEX_WIDTH-1:0] leafStart [2],
    input  logic [PRIM_COUNT_WIDTH-1:0] leafCount [2],
    // Node request and leaf report
    output logic [NODE_INDEX_WIDTH-1:0] nodeIndex,
    output logic                        valid,
    output logic [PRIM_INDEX_WIDTH-1:0] startPrim [2],
    output logic [PRIM_COUNT_WIDTH-1:0] numPrim [2],
    output logic                        finished
);

    // Decoder to state machine
    logic                        pushMask [2];
    logic [NODE_INDEX_WIDTH-1:0] pushIndex [2];
    logic                        leafSelect [2];

    // State machine to stack
    logic                        stackPush;
    logic                        stackPop;
    logic                        stackClear;
    logic                        stackPushMask [2];
    logic [NODE_INDEX_WIDTH-1:0] stackPushIndex [2];
    logic [NODE_INDEX_WIDTH-1:0] topIndex;
    logic                        stackEmpty;

    nodeStack #(
        .STACK_DEPTH(STACK_DEPTH)
    ) u_stack (
        .clk      (clk),
        .resetn   (resetn),
        .clear    (stackClear),
        .push     (stackPush),
        .pushMask (stackPushMask),
        .pushIndex(stackPushIndex),
        .pop      (stackPop),
        .topIndex (topIndex),
        .empty    (stackEmpty)
    );

    childDecode u_decode (
        .nodeHit   (nodeHit),
        .childIndex(childIndex),
        .leafHit   (leafHit),
        .pushMask  (pushMask),
        .pushIndex (pushIndex),
        .leafSelect(leafSelect)
    );

    traversalFsm #(
        .STACK_DEPTH(STACK_DEPTH)
    ) u_fsm (
        .clk           (clk),
        .resetn        (resetn),
        .start         (start),
        .restart       (restart),
        .pushMask      (pushMask),
        .pushIndex     (pushIndex),
        .leafSelect    (leafSelect),
        .leafStart     (leafStart),
        .leafCount     (leafCount),
        .topIndex      (topIndex),
        .empty         (stackEmpty),
        .push          (stackPush),
        .pop           (stackPop),
        .clear         (stackClear),
        .stackPushMask (stackPushMask),
        .stackPushIndex(stackPushIndex),
        .nodeIndex     (nodeIndex),
        .valid         (valid),
        .startPrim     (startPrim),
        .numPrim       (numPrim),
        .finished      (finished)
    );

endmodule

`default_nettype wire

// ==== verilog/traversalFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module traversalFsm
    import bvhPkg::*;
#(
    parameter int STACK_DEPTH = 16
) (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        start,
    input  logic                        restart,
    input  logic                        pushMask [2],
    input  logic [NODE_INDEX_WIDTH-1:0] pushIndex [2],
    input  logic                        leafSelect [2],
    input  logic [PRIM_INDEX_WIDTH-1:0] leafStart [2],
    input  logic [PRIM_COUNT_WIDTH-1:0] leafCount [2],
    input  logic [NODE_INDEX_WIDTH-1:0] topIndex,
    input  logic                        empty,
    output logic                        push,
    output logic                        pop,
    output logic                        clear,
    output logic                        stackPushMask [2],
    output logic [NODE_INDEX_WIDTH-1:0] stackPushIndex [2],
    output logic [NODE_INDEX_WIDTH-1:0] nodeIndex,
    output logic                        valid,
    output logic [PRIM_INDEX_WIDTH-1:0] startPrim [2],
    output logic [PRIM_COUNT_WIDTH-1:0] numPrim [2],
    output logic                        finished
);

    localparam int LEVEL_WIDTH = $clog2(STACK_DEPTH + 1);

    traversalState          state;
    logic [LEVEL_WIDTH-1:0] stackLevel;
    logic                   inProcess;

    // ------------------------------------------------------------------------
    // Stack interface
    // ------------------------------------------------------------------------

    assign inProcess = (state == Process) && !restart;

    // Shadow level keeps requests within the stack depth
    always_comb begin
        stackPushMask[0] = inProcess && pushMask[0] && (stackLevel < STACK_DEPTH);
        stackPushMask[1] = inProcess && pushMask[1]
            && ((stackLevel + LEVEL_WIDTH'(stackPushMask[0])) < STACK_DEPTH);
        for (int i = 0; i < 2; i++) begin
            stackPushIndex[i] = pushIndex[i];
        end
    end

    assign push = stackPushMask[0] || stackPushMask[1];
    assign pop = (state == Fetch) && !empty && !restart;
    assign clear = (state == Idle) && start && !restart;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            stackLevel <= '0;
        end else if (clear) begin
            stackLevel <= '0;
        end else if (pop) begin
            stackLevel <= stackLevel - 1'b1;
        end else if (push) begin
            stackLevel <= stackLevel + LEVEL_WIDTH'(stackPushMask[0])
                + LEVEL_WIDTH'(stackPushMask[1]);
        end
    end

    // ------------------------------------------------------------------------
    // State and registered leaf outputs
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= Idle;
            nodeIndex <= '0;
            finished <= 1'b1;
            valid <= 1'b0;
            for (int i = 0; i < 2; i++) begin
                startPrim[i] <= NULL_PRIM_INDEX;
                numPrim[i] <= '0;
            end
        end else begin
            // Slots are empty unless a Process cycle fills them
            valid <= 1'b0;
            for (int i = 0; i < 2; i++) begin
                startPrim[i] <= NULL_PRIM_INDEX;
                numPrim[i] <= '0;
            end

            if (restart) begin
                state <= Idle;
                finished <= 1'b1;
            end else begin
                case (state)
                    Idle: begin
                        finished <= 1'b1;
                        if (start) begin
                            nodeIndex <= '0;
                            finished <= 1'b0;
                            state <= Process;
                        end
                    end
                    Process: begin
                        valid <= leafSelect[0] || leafSelect[1];
                        for (int i = 0; i < 2; i++) begin
                            if (leafSelect[i]) begin
                                startPrim[i] <= leafStart[i];
                                numPrim[i] <= leafCount[i];
                            end
                        end
                        state <= Fetch;
                    end
                    Fetch: begin
                        if (!empty) begin
                            nodeIndex <= topIndex;
                            state <= Process;
                        end else begin
                            finished <= 1'b1;
                            state <= Done;
                        end
                    end
                    Done: begin
                        finished <= 1'b1;
                    end
                    default: begin
                        state <= Idle;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/childDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module childDecode
    import bvhPkg::*;
(
    input  logic                        nodeHit,
    input  logic [NODE_INDEX_WIDTH-1:0] childIndex [2],
    input  logic                        leafHit [2],
    output logic                        pushMask [2],
    output logic [NODE_INDEX_WIDTH-1:0] pushIndex [2],
    output logic                        leafSelect [2]
);

    // ------------------------------------------------------------------------
    // Per child classification
    // ------------------------------------------------------------------------

    logic isLeaf [2];

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            isLeaf[i] = childIndex[i][LEAF_FLAG_BIT];
        end
    end

    // Inner children of a hit node go onto the stack
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            pushMask[i] = nodeHit && !isLeaf[i];
            if (pushMask[i]) begin
                pushIndex[i] = childIndex[i];
            end else begin
                pushIndex[i] = '0;
            end
        end
    end

    // Leaf children count only when both the node and the leaf are hit
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            leafSelect[i] = nodeHit && isLeaf[i] && leafHit[i];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/nodeStack.sv ====
`timescale 1ns/1ps
`default_nettype none

module nodeStack
    import bvhPkg::*;
#(
    parameter int STACK_DEPTH = 16
) (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        clear,
    input  logic                        push,
    input  logic                        pushMask [2],
    input  logic [NODE_INDEX_WIDTH-1:0] pushIndex [2],
    input  logic                        pop,
    output logic [NODE_INDEX_WIDTH-1:0] topIndex,
    output logic                        empty
);

    localparam int LEVEL_WIDTH = $clog2(STACK_DEPTH + 1);
    localparam int ADDR_WIDTH = $clog2(STACK_DEPTH);

    logic [NODE_INDEX_WIDTH-1:0] entries [STACK_DEPTH];
    logic [LEVEL_WIDTH-1:0]      level;
    logic [LEVEL_WIDTH:0]        slotPos [2];
    logic                        slotWrite [2];
    logic [LEVEL_WIDTH:0]        pushLevel;
    logic [ADDR_WIDTH-1:0]       topSlot;

    // Slot 1 lands right above slot 0 when slot 0 is used
    always_comb begin
        slotPos[0] = {1'b0, level};
        slotPos[1] = {1'b0, level} + (LEVEL_WIDTH + 1)'(pushMask[0]);
        for (int i = 0; i < 2; i++) begin
            slotWrite[i] = push && !clear && pushMask[i] && (slotPos[i] < STACK_DEPTH);
        end
        pushLevel = slotPos[1] + (LEVEL_WIDTH + 1)'(pushMask[1]);
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (slotWrite[i]) begin
                entries[slotPos[i][ADDR_WIDTH-1:0]] <= pushIndex[i];
            end
        end
    end

    // Level saturates at full depth and drops extra pushes
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            level <= '0;
        end else if (clear) begin
            level <= '0;
        end else if (pop && !empty) begin
            level <= level - 1'b1;
        end else if (push) begin
            if (pushLevel > STACK_DEPTH) begin
                level <= LEVEL_WIDTH'(STACK_DEPTH);
            end else begin
                level <= pushLevel[LEVEL_WIDTH-1:0];
            end
        end
    end

    assign empty = (level == '0);
    assign topSlot = ADDR_WIDTH'(level - 1'b1);
    assign topIndex = empty ? '0 : entries[topSlot];

endmodule

`default_nettype wire

// ==== verilog/bvhPkg.sv ====
`default_nettype none

package bvhPkg;

    // ------------------------------------------------------------------------
    // Index and count widths
    // ------------------------------------------------------------------------

    // Node index whose top bit marks a leaf
    localparam int NODE_INDEX_WIDTH = 8;

    // First primitive of a leaf
    localparam int PRIM_INDEX_WIDTH = 16;

    // Number of primitives in a leaf
    localparam int PRIM_COUNT_WIDTH = 4;

    // Bit position of the leaf flag inside a node index
    localparam int LEAF_FLAG_BIT = NODE_INDEX_WIDTH - 1;

    // Start index reported for an empty slot
    localparam logic [PRIM_INDEX_WIDTH-1:0] NULL_PRIM_INDEX = '1;

    // ------------------------------------------------------------------------
    // Traversal states
    // ------------------------------------------------------------------------

    typedef enum logic [1:0] {
        Idle    = 2'd0,
        Process = 2'd1,
        Fetch   = 2'd2,
        Done    = 2'd3
    } traversalState;

endpackage

`default_nettype wire
